// File: compile.f
design/rx_pkg.sv
design/signal_field_check.sv
design/fcs_crc32.sv
design/rx_frame_ctrl.sv
design/rx_frame_top.sv
sim/rx_frame_assertions.sv
sim/rx_frame_tb.sv

// File: design/fcs_crc32.sv
`timescale 1ns/100ps
`default_nettype none

module fcs_crc32 (
    input  wire        clock,
    input  wire        equalizer_reset,
    input  wire  [7:0] byte_i,
    input  wire        fcs_clear_i,
    input  wire        fcs_update_i,
    output logic       fcs_match_o
);

    import rx_pkg::*;

    logic [FCS_W-1:0] crc_q;
    logic [FCS_W-1:0] crc_next;

    // one byte per cycle, lsb of the byte goes in first
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ byte_i[i]) begin
                crc_next = (crc_next >> 1) ^ FCS_POLY_REFLECTED;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            crc_q <= '1;
        end else if (fcs_clear_i) begin
            crc_q <= '1;
        end else if (fcs_update_i) begin
            crc_q <= crc_next;
        end
    end

    // data followed by its own fcs leaves a fixed residue
    assign fcs_match_o = (crc_q == FCS_RESIDUE);

endmodule

`default_nettype wire

// File: design/rx_frame_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_ctrl (
    input  wire                               clock,
    input  wire                               equalizer_reset,
    input  wire signed [rx_pkg::RSSI_W-1:0]   rssi_half_db_i,
    input  wire signed [rx_pkg::RSSI_W-1:0]   power_thres_i,
    input  wire        [7:0]                  byte_i,
    input  wire                               byte_valid_i,
    input  wire rx_pkg::status_e              field_status_i,
    input  wire        [rx_pkg::RATE_W-1:0]   legacy_rate_i,
    input  wire        [rx_pkg::LEN_W-1:0]    legacy_len_i,
    input  wire                               fcs_match_i,
    output logic                              sig_shift_o,
    output logic                              fcs_clear_o,
    output logic                              fcs_update_o,
    output logic                              demod_ongoing_o,
    output logic                              pkt_begin_o,
    output logic                              pkt_header_valid_o,
    output logic                              pkt_header_valid_strobe_o,
    output rx_pkg::status_e                   status_o,
    output logic       [rx_pkg::RATE_W-1:0]   pkt_rate_o,
    output logic       [rx_pkg::LEN_W-1:0]    pkt_len_o,
    output logic       [7:0]                  data_byte_o,
    output logic                              data_byte_strobe_o,
    output logic                              fcs_out_strobe_o,
    output logic                              fcs_ok_o
);

    import rx_pkg::*;

    rx_state_e state;

    logic signed [RSSI_W-1:0] rssi_q;
    logic signed [RSSI_W-1:0] thres_q;
    logic                     power_trigger;

    logic [SIG_CNT_W-1:0] sig_count;
    logic [LEN_W-1:0]     data_count;
    logic [1:0]           done_phase;
    logic                 data_accept;

    //////////////////////////////////////////////////
    // power gating
    //////////////////////////////////////////////////

    // reset values keep the trigger low until real samples load
    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            rssi_q  <= {1'b1, {(RSSI_W-1){1'b0}}};
            thres_q <= {1'b0, {(RSSI_W-1){1'b1}}};
        end else begin
            rssi_q  <= rssi_half_db_i;
            thres_q <= power_thres_i;
        end
    end

    assign power_trigger = (rssi_q >= thres_q);

    //////////////////////////////////////////////////
    // byte acceptance and helper controls
    //////////////////////////////////////////////////

    // stop shifting once three SIGNAL bytes are in
    assign sig_shift_o = (state == S_DECODE_SIGNAL) && byte_valid_i &&
                         (sig_count != SIG_CNT_W'(SIGNAL_BYTES));

    assign data_accept = (state == S_DECODE_DATA) && byte_valid_i &&
                         (data_count != pkt_len_o);

    assign fcs_update_o = data_accept;

    // acts on the same edge that enters S_DECODE_DATA
    assign fcs_clear_o = (state == S_CHECK_SIGNAL) && (field_status_i == ST_OK);

    // payload path
    always_ff @(posedge clock) begin
        if (data_accept) begin
            data_byte_o <= byte_i;
        end
    end

    //////////////////////////////////////////////////
    // receive FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            state                     <= S_WAIT_POWER;
            sig_count                 <= '0;
            data_count                <= '0;
            done_phase                <= '0;
            demod_ongoing_o           <= 1'b0;
            pkt_begin_o               <= 1'b0;
            pkt_header_valid_o        <= 1'b0;
            pkt_header_valid_strobe_o <= 1'b0;
            status_o                  <= ST_OK;
            pkt_rate_o                <= '0;
            pkt_len_o                 <= '0;
            data_byte_strobe_o        <= 1'b0;
            fcs_out_strobe_o          <= 1'b0;
            fcs_ok_o                  <= 1'b0;
        end else begin
            data_byte_strobe_o <= data_accept;

            case (state)
                S_WAIT_POWER: begin
                    sig_count  <= '0;
                    data_count <= '0;
                    done_phase <= '0;
                    if (power_trigger) begin
                        demod_ongoing_o <= 1'b1;
                        state           <= S_DECODE_SIGNAL;
                    end
                end

                S_DECODE_SIGNAL: begin
                    if (sig_shift_o) begin
                        sig_count <= sig_count + 1'b1;
                    end
                    if (sig_count == SIG_CNT_W'(SIGNAL_BYTES)) begin
                        sig_count <= '0;
                        state     <= S_CHECK_SIGNAL;
                    end else if (sig_count == '0 && !byte_valid_i && !power_trigger) begin
                        // power gone before any SIGNAL byte
                        demod_ongoing_o <= 1'b0;
                        state           <= S_WAIT_POWER;
                    end
                end

                S_CHECK_SIGNAL: begin
                    pkt_header_valid_strobe_o <= 1'b1;
                    status_o                  <= field_status_i;
                    if (field_status_i == ST_OK) begin
                        pkt_header_valid_o <= 1'b1;
                        pkt_begin_o        <= 1'b1;
                        pkt_rate_o         <= legacy_rate_i;
                        pkt_len_o          <= legacy_len_i;
                        data_count         <= '0;
                        state              <= S_DECODE_DATA;
                    end else begin
                        state <= S_SIGNAL_ERROR;
                    end
                end

                S_SIGNAL_ERROR: begin
                    pkt_header_valid_strobe_o <= 1'b0;
                    demod_ongoing_o           <= 1'b0;
                    state                     <= S_WAIT_POWER;
                end

                S_DECODE_DATA: begin
                    pkt_begin_o               <= 1'b0;
                    pkt_header_valid_o        <= 1'b0;
                    pkt_header_valid_strobe_o <= 1'b0;
                    if (data_accept) begin
                        data_count <= data_count + 1'b1;
                    end
                    // length covers the fcs bytes too
                    if (data_count == pkt_len_o) begin
                        state <= S_DECODE_DONE;
                    end
                end

                S_DECODE_DONE: begin
                    done_phase <= done_phase + 1'b1;
                    case (done_phase)
                        2'd0: begin
                            fcs_out_strobe_o <= 1'b1;
                            fcs_ok_o         <= fcs_match_i;
                            status_o         <= fcs_match_i ? ST_OK : ST_WRONG_FCS;
                        end
                        2'd1: begin
                            fcs_out_strobe_o <= 1'b0;
                            fcs_ok_o         <= 1'b0;
                        end
                        default: begin
                            done_phase      <= '0;
                            demod_ongoing_o <= 1'b0;
                            state           <= S_WAIT_POWER;
                        end
                    endcase
                end

                default: begin
                    demod_ongoing_o <= 1'b0;
                    state           <= S_WAIT_POWER;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/rx_frame_top.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_top (
    input  wire                               clock,
    input  wire                               equalizer_reset,
    input  wire signed [rx_pkg::RSSI_W-1:0]   rssi_half_db_i,
    input  wire signed [rx_pkg::RSSI_W-1:0]   power_thres_i,
    input  wire        [7:0]                  byte_i,
    input  wire                               byte_valid_i,
    output logic                              demod_ongoing_o,
    output logic                              pkt_begin_o,
    output logic                              pkt_header_valid_o,
    output logic                              pkt_header_valid_strobe_o,
    output rx_pkg::status_e                   status_o,
    output logic       [rx_pkg::RATE_W-1:0]   pkt_rate_o,
    output logic       [rx_pkg::LEN_W-1:0]    pkt_len_o,
    output logic       [7:0]                  data_byte_o,
    output logic                              data_byte_strobe_o,
    output logic                              fcs_out_strobe_o,
    output logic                              fcs_ok_o
);

    import rx_pkg::*;

    // checker results
    status_e           field_status;
    logic [RATE_W-1:0] legacy_rate;
    logic [LEN_W-1:0]  legacy_len;

    // helper controls
    logic sig_shift;
    logic fcs_clear;
    logic fcs_update;
    logic fcs_match;

    rx_frame_ctrl u_rx_frame_ctrl (
        .clock                     (clock),
        .equalizer_reset           (equalizer_reset),
        .rssi_half_db_i            (rssi_half_db_i),
        .power_thres_i             (power_thres_i),
        .byte_i                    (byte_i),
        .byte_valid_i              (byte_valid_i),
        .field_status_i            (field_status),
        .legacy_rate_i             (legacy_rate),
        .legacy_len_i              (legacy_len),
        .fcs_match_i               (fcs_match),
        .sig_shift_o               (sig_shift),
        .fcs_clear_o               (fcs_clear),
        .fcs_update_o              (fcs_update),
        .demod_ongoing_o           (demod_ongoing_o),
        .pkt_begin_o               (pkt_begin_o),
        .pkt_header_valid_o        (pkt_header_valid_o),
        .pkt_header_valid_strobe_o (pkt_header_valid_strobe_o),
        .status_o                  (status_o),
        .pkt_rate_o                (pkt_rate_o),
        .pkt_len_o                 (pkt_len_o),
        .data_byte_o               (data_byte_o),
        .data_byte_strobe_o        (data_byte_strobe_o),
        .fcs_out_strobe_o          (fcs_out_strobe_o),
        .fcs_ok_o                  (fcs_ok_o)
    );

    signal_field_check u_signal_field_check (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .byte_i          (byte_i),
        .sig_shift_i     (sig_shift),
        .field_status_o  (field_status),
        .legacy_rate_o   (legacy_rate),
        .legacy_len_o    (legacy_len)
    );

    fcs_crc32 u_fcs_crc32 (
        .clock           (clock),
        .equalizer_reset (equalizer_reset),
        .byte_i          (byte_i),
        .fcs_clear_i     (fcs_clear),
        .fcs_update_i    (fcs_update),
        .fcs_match_o     (fcs_match)
    );

endmodule

`default_nettype wire

// File: design/rx_pkg.sv
`default_nettype none

package rx_pkg;

    //////////////////////////////////////////////////
    // receiver states and packet status codes
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        S_WAIT_POWER    = 3'd0,
        S_DECODE_SIGNAL = 3'd1,
        S_CHECK_SIGNAL  = 3'd2,
        S_SIGNAL_ERROR  = 3'd3,
        S_DECODE_DATA   = 3'd4,
        S_DECODE_DONE   = 3'd5
    } rx_state_e;

    typedef enum logic [2:0] {
        ST_OK               = 3'd0,
        ST_PARITY_FAIL      = 3'd1,
        ST_WRONG_RSVD       = 3'd2,
        ST_WRONG_TAIL       = 3'd3,
        ST_UNSUPPORTED_RATE = 3'd4,
        ST_WRONG_FCS        = 3'd5
    } status_e;

    //////////////////////////////////////////////////
    // field widths
    //////////////////////////////////////////////////

    // legacy SIGNAL is one OFDM symbol at BPSK 1/2, 24 bits
    localparam int unsigned SIGNAL_BYTES = 3;
    localparam int unsigned SIG_CNT_W    = $clog2(SIGNAL_BYTES + 1);

    localparam int unsigned RATE_W = 4;
    localparam int unsigned LEN_W  = 12;

    // rssi and threshold in half dB steps, signed
    localparam int unsigned RSSI_W = 11;

    // ethernet style crc-32, lsb first
    localparam int unsigned         FCS_W              = 32;
    localparam logic [FCS_W-1:0]    FCS_POLY_REFLECTED = 32'hedb88320;
    localparam logic [FCS_W-1:0]    FCS_RESIDUE        = 32'hdebb20e3;

endpackage

`default_nettype wire

// File: design/signal_field_check.sv
`timescale 1ns/100ps
`default_nettype none

module signal_field_check (
    input  wire                        clock,
    input  wire                        equalizer_reset,
    input  wire  [7:0]                 byte_i,
    input  wire                        sig_shift_i,
    output rx_pkg::status_e            field_status_o,
    output logic [rx_pkg::RATE_W-1:0]  legacy_rate_o,
    output logic [rx_pkg::LEN_W-1:0]   legacy_len_o
);

    import rx_pkg::*;

    logic [8*SIGNAL_BYTES-1:0] signal_bits;

    logic       sig_rsvd;
    logic       sig_parity_ok;
    logic [5:0] sig_tail;

    //////////////////////////////////////////////////
    // SIGNAL assembly
    //////////////////////////////////////////////////

    // bytes enter at the top, first byte ends in the low byte
    always_ff @(posedge clock) begin
        if (equalizer_reset) begin
            signal_bits <= '0;
        end else if (sig_shift_i) begin
            signal_bits <= {byte_i, signal_bits[8*SIGNAL_BYTES-1:8]};
        end
    end

    // field slices
    assign legacy_rate_o = signal_bits[3:0];
    assign sig_rsvd      = signal_bits[4];
    assign legacy_len_o  = signal_bits[16:5];
    assign sig_tail      = signal_bits[23:18];

    // even parity over rate, reserved, length and parity bit
    assign sig_parity_ok = ~^signal_bits[17:0];

    //////////////////////////////////////////////////
    // verdict
    //////////////////////////////////////////////////

    // first failing check wins
    always_comb begin
        if (!sig_parity_ok) begin
            field_status_o = ST_PARITY_FAIL;
        end else if (sig_rsvd) begin
            field_status_o = ST_WRONG_RSVD;
        end else if (|sig_tail) begin
            field_status_o = ST_WRONG_TAIL;
        end else if (!legacy_rate_o[3]) begin
            // all legal legacy rates carry bit 3 set
            field_status_o = ST_UNSUPPORTED_RATE;
        end else begin
            field_status_o = ST_OK;
        end
    end

endmodule

`default_nettype wire

// File: sim/rx_frame_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_assertions (
    input wire clock,
    input wire equalizer_reset,
    input wire demod_ongoing_i,
    input wire pkt_header_valid_i,
    input wire pkt_header_valid_strobe_i,
    input wire data_byte_strobe_i,
    input wire fcs_out_strobe_i
);

    // read by the testbench monitor
    int unsigned fail_count = 0;

    header_strobe_single : assert property (@(posedge clock) disable iff (equalizer_reset)
        pkt_header_valid_strobe_i |=> !pkt_header_valid_strobe_i)
        else begin
            fail_count++;
            $error("header strobe high for more than one cycle");
        end

    fcs_strobe_single : assert property (@(posedge clock) disable iff (equalizer_reset)
        fcs_out_strobe_i |=> !fcs_out_strobe_i)
        else begin
            fail_count++;
            $error("fcs strobe high for more than one cycle");
        end

    // valid header only ever shows up with its strobe
    header_valid_with_strobe : assert property (@(posedge clock) disable iff (equalizer_reset)
        pkt_header_valid_i |-> pkt_header_valid_strobe_i)
        else begin
            fail_count++;
            $error("header valid without header strobe");
        end

    data_inside_packet : assert property (@(posedge clock) disable iff (equalizer_reset)
        data_byte_strobe_i |-> demod_ongoing_i)
        else begin
            fail_count++;
            $error("data byte strobe outside a packet");
        end

endmodule

bind rx_frame_top rx_frame_assertions u_rx_frame_assertions (
    .clock                     (clock),
    .equalizer_reset           (equalizer_reset),
    .demod_ongoing_i           (demod_ongoing_o),
    .pkt_header_valid_i        (pkt_header_valid_o),
    .pkt_header_valid_strobe_i (pkt_header_valid_strobe_o),
    .data_byte_strobe_i        (data_byte_strobe_o),
    .fcs_out_strobe_i          (fcs_out_strobe_o)
);

`default_nettype wire

// File: sim/rx_frame_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rx_frame_tb;

    import rx_pkg::*;

    localparam int unsigned NUM_PACKETS = 200;
    localparam int unsigned TIMEOUT     = 2000;
    localparam int unsigned SEL_DEMOD   = 0;
    localparam int unsigned SEL_HEADER  = 1;
    localparam int unsigned SEL_FCS     = 2;

    logic                     clock;
    logic                     equalizer_reset;
    logic signed [RSSI_W-1:0] rssi_half_db_i;
    logic signed [RSSI_W-1:0] power_thres_i;
    logic [7:0]               byte_i;
    logic                     byte_valid_i;
    logic                     demod_ongoing_o;
    logic                     pkt_begin_o;
    logic                     pkt_header_valid_o;
    logic                     pkt_header_valid_strobe_o;
    status_e                  status_o;
    logic [RATE_W-1:0]        pkt_rate_o;
    logic [LEN_W-1:0]         pkt_len_o;
    logic [7:0]               data_byte_o;
    logic                     data_byte_strobe_o;
    logic                     fcs_out_strobe_o;
    logic                     fcs_ok_o;

    logic [31:0] rng_state = 32'hc498_2cfa;
    logic [7:0]  expected_bytes[$];
    int unsigned header_strobes = 0;

    rx_frame_top u_rx_frame_top (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // reflected crc-32, one byte lsb first
    function automatic logic [31:0] crc_update(input logic [31:0] crc, input logic [7:0] data);
        for (int i = 0; i < 8; i++) begin
            crc = (crc[0] ^ data[i]) ? ((crc >> 1) ^ FCS_POLY_REFLECTED) : (crc >> 1);
        end
        return crc;
    endfunction

    function automatic logic sample_output(input int unsigned sel);
        case (sel)
            SEL_DEMOD:  return demod_ongoing_o;
            SEL_HEADER: return pkt_header_valid_strobe_o;
            default:    return fcs_out_strobe_o;
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_status(input status_e got, input status_e exp);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] status_o: got 0x%0h expected 0x%0h", got, exp));
        end
    endtask

    task automatic check_rate_len(input logic [RATE_W-1:0] got_rate,
                                  input logic [RATE_W-1:0] exp_rate,
                                  input logic [LEN_W-1:0]  got_len,
                                  input logic [LEN_W-1:0]  exp_len);
        if (got_rate !== exp_rate) begin
            report_failure($sformatf("[ERROR] pkt_rate_o: got 0x%0h expected 0x%0h",
                                     got_rate, exp_rate));
        end
        if (got_len !== exp_len) begin
            report_failure($sformatf("[ERROR] pkt_len_o: got 0x%0h expected 0x%0h",
                                     got_len, exp_len));
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] data_byte_o: got 0x%0h expected 0x%0h", got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // polls at falling edges, starting with the current one
    task automatic wait_until(input int unsigned sel, input logic level, input string what);
        int unsigned cycles;
        cycles = 0;
        while (sample_output(sel) !== level) begin
            if (cycles == TIMEOUT) begin
                report_failure($sformatf("timeout after %0d cycles waiting for %s", cycles, what));
            end
            @(negedge clock);
            cycles++;
        end
    endtask

    // called at a falling edge, returns at the next one with valid low
    task automatic send_byte(input logic [7:0] data);
        byte_i       = data;
        byte_valid_i = 1'b1;
        @(negedge clock);
        byte_valid_i = 1'b0;
    endtask

    task automatic raise_power();
        int thres;
        thres          = int'(next_random() % 601) - 300;
        power_thres_i  = RSSI_W'(thres);
        rssi_half_db_i = RSSI_W'(thres + int'(next_random() % 50));
        wait_until(SEL_DEMOD, 1'b1, "demod_ongoing_o to rise");
    endtask

    task automatic finish_packet();
        rssi_half_db_i = power_thres_i - RSSI_W'(1 + next_random() % 50);
        wait_until(SEL_DEMOD, 1'b0, "demod_ongoing_o to fall");
        repeat (10) @(negedge clock);
    endtask

    //////////////////////////////////////////////////
    // packet model and stimulus
    //////////////////////////////////////////////////

    task automatic abort_before_signal();
        int unsigned strobes_before;
        strobes_before = header_strobes;
        raise_power();
        repeat (next_random() % 4) @(negedge clock);
        finish_packet();
        if (header_strobes != strobes_before) begin
            report_failure("header strobe seen after power dropped before any byte");
        end
    endtask

    // kinds 0 to 1 good, 2 bad fcs, 3 parity, 4 reserved, 5 tail, 6 rate
    task automatic run_packet(input int unsigned kind);
        logic [31:0]       r;
        logic [RATE_W-1:0] rate;
        logic [LEN_W-1:0]  len;
        logic              rsvd;
        logic [5:0]        tail;
        logic              parity;
        logic [23:0]       sig;
        logic [31:0]       crc;
        logic [7:0]        frame[$];
        status_e           exp_status;
        int unsigned       junk_count;
        r          = next_random();
        rate       = {1'b1, r[2:0]};
        len        = LEN_W'(4 + (r[15:8] % 37));
        rsvd       = 1'b0;
        tail       = 6'd0;
        exp_status = ST_OK;
        // later checks may fail too, the first in order decides
        case (kind)
            3: begin
                exp_status = ST_PARITY_FAIL;
                rsvd       = r[16];
                tail       = r[22:17];
                rate[3]    = r[23];
            end
            4: begin
                exp_status = ST_WRONG_RSVD;
                rsvd       = 1'b1;
                tail       = r[22:17];
                rate[3]    = r[23];
            end
            5: begin
                exp_status = ST_WRONG_TAIL;
                tail       = r[22:17] | 6'd1;
                rate[3]    = r[23];
            end
            6: begin
                exp_status = ST_UNSUPPORTED_RATE;
                rate[3]    = 1'b0;
            end
            default: begin
                exp_status = ST_OK;
            end
        endcase
        parity = (^{len, rsvd, rate}) ^ (kind == 3);
        sig    = {tail, parity, len, rsvd, rate};

        raise_power();
        for (int i = 0; i < SIGNAL_BYTES; i++) begin
            repeat (next_random() % 4) @(negedge clock);
            send_byte(sig[8*i +: 8]);
        end
        wait_until(SEL_HEADER, 1'b1, "pkt_header_valid_strobe_o");
        check_status(status_o, exp_status);
        check_bit("pkt_header_valid_o", pkt_header_valid_o, exp_status == ST_OK);
        check_bit("pkt_begin_o", pkt_begin_o, exp_status == ST_OK);

        if (exp_status == ST_OK) begin
            check_rate_len(pkt_rate_o, rate, pkt_len_o, len);
            crc = '1;
            for (int i = 0; i < len - 4; i++) begin
                frame.push_back(8'(next_random()));
                crc = crc_update(crc, frame[i]);
            end
            crc = ~crc;
            if (kind == 2) begin
                crc ^= 32'd1 << (next_random() % 32);
            end
            for (int i = 0; i < 4; i++) begin
                frame.push_back(crc[8*i +: 8]);
            end
            // at least 3 idle cycles after the last SIGNAL byte
            repeat (1 + next_random() % 3) @(negedge clock);
            foreach (frame[i]) begin
                if (i > 0) begin
                    repeat (next_random() % 4) @(negedge clock);
                end
                expected_bytes.push_back(frame[i]);
                send_byte(frame[i]);
            end
            wait_until(SEL_FCS, 1'b1, "fcs_out_strobe_o");
            exp_status = (kind == 2) ? ST_WRONG_FCS : ST_OK;
            check_bit("fcs_ok_o", fcs_ok_o, kind != 2);
            check_status(status_o, exp_status);
            if (expected_bytes.size() != 0) begin
                report_failure("fewer data bytes forwarded than pkt_len");
            end
        end else begin
            // bytes after a rejected header must not reach the data path
            rssi_half_db_i = power_thres_i - RSSI_W'(1 + next_random() % 50);
            junk_count     = 1 + next_random() % 4;
            for (int i = 0; i < junk_count; i++) begin
                if (i > 0) begin
                    repeat (next_random() % 4) @(negedge clock);
                end
                send_byte(8'(next_random()));
            end
        end
        finish_packet();
    endtask

    // data byte and header strobe monitor
    initial begin
        forever begin
            @(negedge clock);
            if (u_rx_frame_top.u_rx_frame_assertions.fail_count != 0) begin
                report_failure("a concurrent assertion failed");
            end
            if (pkt_header_valid_strobe_o === 1'b1) begin
                header_strobes++;
            end
            if (data_byte_strobe_o === 1'b1) begin
                if (expected_bytes.size() == 0) begin
                    report_failure("data byte strobe with no data byte expected");
                end
                check_byte(data_byte_o, expected_bytes.pop_front());
            end
        end
    end

    initial begin
        int unsigned kind;
        logic        force_good;
        equalizer_reset = 1'b1;
        rssi_half_db_i  = RSSI_W'(-100);
        power_thres_i   = '0;
        byte_i          = 8'h00;
        byte_valid_i    = 1'b0;
        force_good      = 1'b0;
        repeat (8) @(negedge clock);
        equalizer_reset = 1'b0;
        repeat (4) @(negedge clock);

        for (int n = 0; n < NUM_PACKETS; n++) begin
            kind = next_random() % 8;
            if (force_good) begin
                kind = 0;
            end
            force_good = (kind == 7);
            if (kind == 7) begin
                abort_before_signal();
            end else begin
                run_packet(kind);
            end
        end

        if (u_rx_frame_top.u_rx_frame_assertions.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            report_failure("concurrent assertion failures were reported");
        end
    end

endmodule

`default_nettype wire
